//--- src/monitor_bus_pkg.sv
package monitor_bus_pkg;

	// Word addressed bus, so the two low byte-address bits are gone
	localparam int addr_w = 30;
	localparam int data_w = 32;

	localparam logic [addr_w-1:0] test_port = 30'hFF; // Results land here

	// Both symbols are given in readable byte order
	localparam logic [data_w-1:0] begin_symbol = 32'h00000168;
	localparam logic [data_w-1:0] end_symbol = 32'hFFFFFD5D;

endpackage

//--- src/monitor_check_pkg.sv
package monitor_check_pkg;

	// Words compared after the begin symbol, the last one being the end symbol
	localparam int check_num = 95;

	// Last index of the rising half, the next index repeats its value
	localparam int peak_index = 46;

	localparam int err_w = 8; // Error counter, reads all ones before a run
	localparam int dur_w = 16; // Cycles spent in check

	typedef enum logic [1:0] {
		idle,
		check,
		report
	} check_state_t;

endpackage

//--- src/wb_if.sv
interface wb_if;
	import monitor_bus_pkg::*;

	logic cyc;
	logic stb;
	logic we;
	logic [addr_w-1:0] adr;
	logic [data_w-1:0] dat;
	logic ack;

	// A transfer completes on an edge with cyc, stb and ack high
	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat,
		input ack
	);

	modport slave (
		input cyc,
		input stb,
		input we,
		input adr,
		input dat,
		output ack
	);

endinterface

//--- src/store_filter.sv
module store_filter (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [monitor_bus_pkg::addr_w-1:0] addr,
	input logic [monitor_bus_pkg::data_w-1:0] data,
	output logic ack,
	wb_if.master out
);
	import monitor_bus_pkg::*;

	logic busy; // A store was taken and is not yet acknowledged
	logic fwd; // Decision made, the word goes out next cycle
	logic out_stb;
	logic take;
	logic [data_w-1:0] data_swap;
	logic [data_w-1:0] word;

	// Processor writes little-endian, the checker wants readable order
	assign data_swap = {data[7:0], data[15:8], data[23:16], data[31:24]};

	assign take = !busy && cyc && stb;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			fwd <= 1'b0;
			out_stb <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (take) begin
				busy <= 1'b1;
				if (we && addr == test_port) begin
					fwd <= 1'b1;
				end else begin
					ack <= 1'b1; // Not for the test port, acknowledge and drop
				end
			end
			if (fwd) begin
				out_stb <= 1'b1;
				fwd <= 1'b0;
			end
			// The outside store finishes only once the FIFO took the word
			if (out_stb && out.ack) begin
				out_stb <= 1'b0;
				ack <= 1'b1;
			end
			if (ack) begin
				busy <= 1'b0; // Master drops stb on this edge
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			word <= data_swap;
		end
	end

	assign out.cyc = out_stb;
	assign out.stb = out_stb;
	assign out.we = 1'b1;
	assign out.adr = test_port;
	assign out.dat = word;

endmodule

//--- src/store_fifo.sv
module store_fifo #(
	parameter int depth = 8
) (
	input logic clk,
	input logic rst,
	wb_if.slave wr,
	wb_if.master rd
);
	import monitor_bus_pkg::*;

	logic [data_w-1:0] mem_dat [depth];
	logic [addr_w-1:0] mem_adr [depth];

	// The extra top bit tells full from empty when the low bits match
	logic [$clog2(depth):0] wptr;
	logic [$clog2(depth):0] rptr;

	logic wr_ack;
	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = wptr == rptr;
	assign full = (wptr[$clog2(depth)] != rptr[$clog2(depth)]) &&
		(wptr[$clog2(depth)-1:0] == rptr[$clog2(depth)-1:0]);

	assign push = wr.cyc && wr.stb && wr_ack && wr.we; // Reads are acked but hold nothing
	assign pop = rd.cyc && rd.stb && rd.ack;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ack <= 1'b0;
			wptr <= '0;
			rptr <= '0;
		end else begin
			// While full the ack stays low and the writer has to wait
			wr_ack <= wr.cyc && wr.stb && !wr_ack && !full;
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem_dat[wptr[$clog2(depth)-1:0]] <= wr.dat;
			mem_adr[wptr[$clog2(depth)-1:0]] <= wr.adr;
		end
	end

	assign wr.ack = wr_ack;

	// Oldest word is offered for as long as anything is stored
	assign rd.cyc = !empty;
	assign rd.stb = !empty;
	assign rd.we = 1'b1;
	assign rd.adr = mem_adr[rptr[$clog2(depth)-1:0]];
	assign rd.dat = mem_dat[rptr[$clog2(depth)-1:0]];

endmodule

//--- src/result_checker.sv
module result_checker (
	input logic clk,
	input logic rst,
	wb_if.slave in,
	output logic [monitor_check_pkg::err_w-1:0] error_num,
	output logic [monitor_check_pkg::dur_w-1:0] duration,
	output logic finish
);
	import monitor_bus_pkg::*;
	import monitor_check_pkg::*;

	check_state_t state;

	logic ack;
	logic take; // A test-port word is consumed on this edge
	logic last;
	logic [$clog2(check_num)-1:0] index;

	// Running pair of terms, cur is the value expected at index
	logic [data_w-1:0] prev;
	logic [data_w-1:0] cur;
	logic [data_w-1:0] expected;

	// Registered ack gives at most one word every other cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack <= 1'b0;
		end else begin
			ack <= in.cyc && in.stb && !ack;
		end
	end

	assign in.ack = ack;

	assign take = in.cyc && in.stb && ack && in.we && in.adr == test_port;
	assign last = index == check_num - 1;
	assign expected = last ? end_symbol : cur;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= idle;
			index <= '0;
			error_num <= '1;
			duration <= '0;
		end else begin
			case (state)
				idle: begin
					// Everything before the begin symbol is dropped
					if (take && in.dat == begin_symbol) begin
						state <= check;
						index <= '0;
						error_num <= '0;
						duration <= '0;
					end
				end
				check: begin
					duration <= duration + 1'b1;
					if (take) begin
						if (in.dat != expected) begin
							error_num <= error_num + 1'b1;
						end
						index <= index + 1'b1;
						if (last) begin
							state <= report;
						end
					end
				end
				report: begin
					state <= report; // Counters freeze until reset
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle) begin
			prev <= data_w'(1); // So that the first sum gives 1 after 0
			cur <= '0;
		end else if (state == check && take) begin
			if (index < peak_index) begin
				prev <= cur;
				cur <= prev + cur;
			end else if (index > peak_index) begin
				// Walking back down the same terms
				prev <= cur - prev;
				cur <= prev;
			end
		end
	end

	assign finish = state == report;

endmodule

//--- src/result_monitor_top.sv
module result_monitor_top (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [monitor_bus_pkg::addr_w-1:0] addr,
	input logic [monitor_bus_pkg::data_w-1:0] data,
	output logic ack,
	output logic [monitor_check_pkg::err_w-1:0] error_num,
	output logic [monitor_check_pkg::dur_w-1:0] duration,
	output logic finish
);

	wb_if store_bus ();
	wb_if check_bus ();

	store_filter i_store_filter (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.addr(addr),
		.data(data),
		.ack(ack),
		.out(store_bus.master)
	);

	// Keeps the store path moving while the checker takes its two cycles per word
	store_fifo #(
		.depth(8)
	) i_store_fifo (
		.clk(clk),
		.rst(rst),
		.wr(store_bus.slave),
		.rd(check_bus.master)
	);

	result_checker i_result_checker (
		.clk(clk),
		.rst(rst),
		.in(check_bus.slave),
		.error_num(error_num),
		.duration(duration),
		.finish(finish)
	);

endmodule

//--- test/tb_result_monitor.sv
module tb_result_monitor;
	timeunit 1ns;
	timeprecision 100ps;
	import monitor_bus_pkg::*;
	import monitor_check_pkg::*;

	localparam int clk_period = 20;
	localparam int reset_cycles = 5;
	localparam int drive_delay = 2;
	localparam int drain_cycles = 60; // Longest wait for the FIFO and checker to empty
	localparam int hold_cycles = 10;
	localparam int max_burst = 12;
	localparam int n_rows = 6;

	// Test table with one independent run per row
	string row_name [n_rows] = '{"clean", "one_bad_word", "many_bad_words",
		"stray_stores", "stray_and_bad", "no_begin"};
	int row_strays [n_rows] = '{0, 0, 0, 40, 60, 20};
	int row_corrupt [n_rows] = '{0, 1, 7, 0, 5, 0};
	bit row_begin [n_rows] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
	int row_exp_errors [n_rows] = '{0, 1, 7, 0, 5, 255};
	bit row_exp_finish [n_rows] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] data;
	logic ack;
	logic [err_w-1:0] error_num;
	logic [dur_w-1:0] duration;
	logic finish;

	int error_count;
	int pass_count;
	int fail_count;

	result_monitor_top i_result_monitor_top (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.addr(addr),
		.data(data),
		.ack(ack),
		.error_num(error_num),
		.duration(duration),
		.finish(finish)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Plain Fibonacci term where F(0) is 0
	function automatic logic [31:0] fib(input int n);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		a = 32'd0;
		b = 32'd1;
		for (int i = 0; i < n; i++) begin
			t = a + b;
			a = b;
			b = t;
		end
		return a;
	endfunction

	// Climb to F(46), repeat it, walk back to F(0), then the end symbol
	function automatic logic [31:0] expected_word(input int idx);
		if (idx <= peak_index) begin
			return fib(idx);
		end else if (idx < check_num - 1) begin
			return fib(2 * peak_index + 1 - idx);
		end
		return end_symbol;
	endfunction

	function automatic logic [31:0] to_little_endian(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic reset_and_check(input string name);
		@(posedge clk);
		#drive_delay;
		rst = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		addr = '0;
		data = '0;
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		rst = 1'b1;
		@(negedge clk);
		compare(32'(ack), 32'd0, {name, " ack after reset"});
		compare(32'(finish), 32'd0, {name, " finish after reset"});
		compare(32'(error_num), 32'd255, {name, " error_num after reset"});
		compare(32'(duration), 32'd0, {name, " duration after reset"});
		@(posedge clk);
		#drive_delay; // Every store starts just after a rising edge
	endtask

	// One external write that is held until the acknowledging edge
	task automatic store(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		addr = a;
		data = d;
		@(negedge clk);
		while (!ack) begin
			@(negedge clk);
		end
		@(posedge clk);
		#drive_delay;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic send_strays(input int n);
		logic [addr_w-1:0] a;
		for (int i = 0; i < n; i++) begin
			a = addr_w'($urandom);
			if (a == test_port) begin
				a = ~a;
			end
			store(a, $urandom);
		end
	endtask

	task automatic run_row(input int r);
		int errors_before;
		int remaining;
		int burst;
		int slot;
		int pos;
		int placed;
		int waited;
		bit corrupt_at [check_num];
		int stray_at [check_num + 1];
		logic [data_w-1:0] word;
		logic [data_w-1:0] flip;
		logic [dur_w-1:0] dur_at_finish;

		errors_before = error_count;
		for (int i = 0; i < check_num; i++) begin
			corrupt_at[i] = 1'b0;
		end
		for (int i = 0; i <= check_num; i++) begin
			stray_at[i] = 0;
		end

		placed = 0;
		while (placed < row_corrupt[r]) begin
			pos = int'($urandom % check_num);
			if (!corrupt_at[pos]) begin
				corrupt_at[pos] = 1'b1;
				placed++;
			end
		end

		// Strays come in bursts and slot i sits in front of word i
		remaining = row_strays[r];
		while (remaining > 0) begin
			burst = 1 + int'($urandom % max_burst);
			if (burst > remaining) begin
				burst = remaining;
			end
			slot = int'($urandom % (check_num + 1));
			stray_at[slot] += burst;
			remaining -= burst;
		end

		reset_and_check(row_name[r]);

		if (row_begin[r]) begin
			store(test_port, to_little_endian(begin_symbol));
		end
		for (int i = 0; i < check_num; i++) begin
			send_strays(stray_at[i]);
			word = expected_word(i);
			if (corrupt_at[i]) begin
				flip = $urandom;
				if (flip == '0) begin
					flip = 32'd1;
				end
				word = word ^ flip;
			end
			store(test_port, to_little_endian(word));
		end
		send_strays(stray_at[check_num]);

		if (row_exp_finish[r]) begin
			waited = 0;
			@(negedge clk);
			while (!finish && waited < drain_cycles) begin
				@(negedge clk);
				waited++;
			end
			if (!finish) begin
				$display("Test %s: finish did not rise within %0d cycles of the last store",
					row_name[r], drain_cycles);
				error_count++;
			end else begin
				compare(32'(error_num), 32'(row_exp_errors[r]), {row_name[r], " error_num"});
				compare(32'(duration >= 2 * check_num), 32'd1,
					{row_name[r], " duration at least two cycles per word"});
				dur_at_finish = duration;
				repeat (hold_cycles) @(negedge clk);
				compare(32'(duration), 32'(dur_at_finish), {row_name[r], " duration after finish"});
				compare(32'(finish), 32'd1, {row_name[r], " finish held"});
			end
		end else begin
			repeat (drain_cycles) @(negedge clk); // Nothing should happen without begin
			compare(32'(finish), 32'd0, {row_name[r], " finish"});
			compare(32'(error_num), 32'(row_exp_errors[r]), {row_name[r], " error_num"});
			compare(32'(duration), 32'd0, {row_name[r], " duration"});
		end

		if (error_count == errors_before) begin
			pass_count++;
			$display("Test %s: ok", row_name[r]);
		end else begin
			fail_count++;
			$display("Test %s: %0d mismatches", row_name[r], error_count - errors_before);
		end
	endtask

	initial begin
		rst = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		addr = '0;
		data = '0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(32'h511f));

		for (int r = 0; r < n_rows; r++) begin
			run_row(r);
		end

		$display("Tests run: %0d, passed: %0d, failed: %0d", n_rows, pass_count, fail_count);
		if (fail_count == 0 && error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Ten cycles per store and ten stores of slack per row
	initial begin
		int limit;
		limit = 0;
		for (int r = 0; r < n_rows; r++) begin
			limit += (check_num + row_strays[r] + 10) * 10;
		end
		#(limit * clk_period);
		$display("Watchdog: the run did not complete within %0d clock cycles", limit);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- all.f
src/monitor_bus_pkg.sv
src/monitor_check_pkg.sv
src/wb_if.sv
src/store_filter.sv
src/store_fifo.sv
src/result_checker.sv
src/result_monitor_top.sv
test/tb_result_monitor.sv

//--- run.sh
#!/bin/sh
# Builds the result monitor testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_result_monitor \
	-f all.f \
	-o sim_result_monitor

./obj_dir/sim_result_monitor > sim.log
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
